// ==== Makefile ====
# Verilator build and regression run for the write phase testbench

VERILATOR ?= verilator
TOP       ?= tb_wr_phase
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard src/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@! grep -q "Regression failed" $(LOG)

check: run
	@grep -q "Regression passed" $(LOG)
	@echo "check ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+src
src/wr_cfg_pkg.sv
src/wr_stream_pkg.sv
src/wr_phase_ctrl.sv
src/wr_addr_pattern_pipe.sv
src/wr_entry_fifo.sv
src/wr_line_issue.sv
src/wr_phase_top.sv
bench/wr_phase_checker.sv
bench/tb_wr_phase.sv

// ==== bench/tb_wr_phase.sv ====
// ==============================
// one phase per table row, back to back, with ready always high or random
// the watchdog budget grows with the number of writes in the table
// ==============================
`default_nettype none
`timescale 1ns/100ps

`include "wr_defines.svh"

module tb_wr_phase;
  import wr_cfg_pkg::*;
  import wr_stream_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  localparam int CYCLES_PER_WRITE = 40;
  localparam int MARGIN_CYCLES = 500;

  // abort_at counts cycles after the start edge, 0 means no abort
  typedef struct packed {
    wr_cfg_t cfg;
    logic rand_ready;
    logic [15:0] abort_at;
    logic [15:0] exp_writes;
  } test_row_t;

  logic clk;
  logic reset_n;
  logic i_start;
  wr_cfg_t i_cfg;
  logic i_abort;
  wr_aw_t o_aw;
  logic i_aw_ready;
  wr_w_t o_w;
  logic i_w_ready;
  logic o_busy;
  logic o_done;

  test_row_t rows[$];
  string row_names[$];
  logic rand_ready;
  integer seed;

  wr_phase_top dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_start    (i_start),
    .i_cfg      (i_cfg),
    .i_abort    (i_abort),
    .o_aw       (o_aw),
    .i_aw_ready (i_aw_ready),
    .o_w        (o_w),
    .i_w_ready  (i_w_ready),
    .o_busy     (o_busy),
    .o_done     (o_done)
  );

  wr_phase_checker chk_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_start    (i_start),
    .i_cfg      (i_cfg),
    .i_abort    (i_abort),
    .i_aw       (o_aw),
    .i_aw_ready (i_aw_ready),
    .i_w        (o_w),
    .i_w_ready  (i_w_ready),
    .i_busy     (o_busy),
    .i_done     (o_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic add_row(
    input string name,
    input logic [`WR_ADDR_W-1:0] x,
    input logic [`WR_PAT_W-1:0] p,
    input logic [`WR_RAI_W-1:0] rai,
    input logic [`WR_N_W-1:0] nai,
    input logic [2:0] size_code,
    input logic [`WR_LINE_BYTES-1:0] mask,
    input logic single,
    input logic random_ready,
    input int abort_at,
    input int exp_writes
  );
    test_row_t row;
    row.cfg.x         = x;
    row.cfg.p         = p;
    row.cfg.rai       = rai;
    row.cfg.nai       = nai;
    row.cfg.pat_size  = pat_size_e'(size_code);
    row.cfg.byte_mask = mask;
    row.cfg.single    = single;
    row.rand_ready    = random_ready;
    row.abort_at      = 16'(abort_at);
    row.exp_writes    = 16'(exp_writes);
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  // expected write counts are nai+1, or 1 in single mode
  task automatic build_table();
    add_row("addr_step_size4", 52'h0_0000_1234_5000, 32'h1000_00F0, 38'h40, 9'd7,
            3'd4, {64{1'b1}}, 1'b0, 1'b0, 0, 8);
    add_row("rai_zero_size2", 52'h0_00AB_CDEF_0000, 32'hA5A5_FFFE, 38'h0, 9'd3,
            3'd2, {64{1'b1}}, 1'b0, 1'b0, 0, 4);
    add_row("size1_sparse_mask", 52'h0_0000_0000_0000, 32'h0000_01FE, 38'h3F_FFFF_FFC0,
            9'd5, 3'd1, 64'h8000_0000_F0F0_0001, 1'b0, 1'b0, 0, 6);
    add_row("size0_full_mask", 52'h0_0000_8000_0000, 32'hDEAD_BEEF, 38'h80, 9'd2,
            3'd0, {64{1'b1}}, 1'b0, 1'b0, 0, 3);
    add_row("unknown_size", 52'h0_0000_9000_0000, 32'h1234_5678, 38'h100, 9'd2,
            3'd3, {64{1'b1}}, 1'b0, 1'b0, 0, 3);
    add_row("zero_mask", 52'h0_0000_A000_0040, 32'h0BAD_F00D, 38'h40, 9'd2,
            3'd4, 64'h0, 1'b0, 1'b0, 0, 3);
    add_row("single_write", 52'h0_0001_0000_0000, 32'hCAFE_0001, 38'h40, 9'd9,
            3'd4, 64'hFF00_FF00_FF00_FF00, 1'b1, 1'b0, 0, 1);
    add_row("random_ready_long", 52'h0_0002_0000_0000, 32'h0000_7FF0, 38'h1000, 9'd60,
            3'd4, 64'h0F0F_0F0F_FFFF_0000, 1'b0, 1'b1, 0, 61);
    add_row("abort_mid_phase", 52'h0_0003_0000_0000, 32'h5555_0000, 38'h40, 9'd50,
            3'd2, {64{1'b1}}, 1'b0, 1'b1, 25, 51);
    add_row("after_abort", 52'h0_0004_0000_0000, 32'h7777_0000, 38'h20, 9'd4,
            3'd4, {64{1'b1}}, 1'b0, 1'b0, 0, 5);
  endtask

  // ready is redrawn every cycle in random mode, high about three cycles in four
  always @(posedge clk)
  begin : ready_drive
    logic [31:0] rnd;
    if (rand_ready)
    begin
      rnd = $random(seed);
      i_aw_ready <= (rnd[1:0] != 2'b00);
      i_w_ready  <= (rnd[5:4] != 2'b00);
    end
    else
    begin
      i_aw_ready <= 1'b1;
      i_w_ready  <= 1'b1;
    end
  end

  // checker calls happen on the falling edge, away from its sampling edge
  task automatic run_row(input int r);
    test_row_t row;
    row = rows[r];
    @(negedge clk);
    rand_ready = row.rand_ready;
    chk_i.open_test(row_names[r], int'(row.exp_writes), row.abort_at != 0);
    @(posedge clk);
    i_cfg   <= row.cfg;
    i_start <= 1'b1;
    // the DUT samples the start pulse on the next edge
    @(posedge clk);
    i_start <= 1'b0;
    if (row.abort_at != 0)
    begin
      repeat (int'(row.abort_at) - 1) @(posedge clk);
      i_abort <= 1'b1;
      @(posedge clk);
      i_abort <= 1'b0;
    end
    do
      @(posedge clk);
    while (!o_done);
    @(negedge clk);
    chk_i.close_test();
  endtask

  initial
  begin
    seed       = 32'hedcb;
    rand_ready = 1'b0;
    reset_n    = 1'b0;
    i_start    = 1'b0;
    i_abort    = 1'b0;
    i_cfg      = '0;
    i_aw_ready = 1'b0;
    i_w_ready  = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    foreach (rows[r])
      run_row(r);
    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             chk_i.tests_run, chk_i.tests_run - chk_i.tests_failed,
             chk_i.tests_failed, chk_i.total_errors);
    if ((chk_i.total_errors == 0) && (chk_i.tests_run == rows.size()))
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin : watchdog
    int limit_cycles;
    wait (reset_n === 1'b1);
    limit_cycles = MARGIN_CYCLES;
    foreach (rows[r])
      limit_cycles += (int'(rows[r].cfg.nai) + 1) * CYCLES_PER_WRITE;
    #(limit_cycles * CLK_PERIOD);
    $display("ERROR watchdog: the run did not finish within %0d cycles", limit_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/wr_phase_checker.sv ====
// ==============================
// open_test must be called before each start pulse and close_test after done
// abort rows only need a prefix of the write sequence
// ==============================
`default_nettype none
`timescale 1ns/100ps

`include "wr_defines.svh"

module wr_phase_checker (
  input  logic clk,
  input  logic reset_n,
  input  logic i_start,
  input  wr_cfg_pkg::wr_cfg_t i_cfg,
  input  logic i_abort,
  input  wr_stream_pkg::wr_aw_t i_aw,
  input  logic i_aw_ready,
  input  wr_stream_pkg::wr_w_t i_w,
  input  logic i_w_ready,
  input  logic i_busy,
  input  logic i_done
);
  import wr_cfg_pkg::*;
  import wr_stream_pkg::*;

  // totals read by the testbench top for the closing line
  int tests_run = 0;
  int tests_failed = 0;
  int total_errors = 0;

  string test_name = "none";
  int exp_count = 0;
  bit abort_row = 1'b0;
  wr_cfg_t cur_cfg;
  bit launched = 1'b0;
  bit phase_open = 1'b0;
  bit abort_seen = 1'b0;
  int abort_age = 0;
  int aw_count = 0;
  int w_count = 0;
  int done_count = 0;
  int errors = 0;

  function automatic int size_in_bytes(pat_size_e sz);
    case (sz)
      PAT_SIZE_4: return 4;
      PAT_SIZE_2: return 2;
      PAT_SIZE_1: return 1;
      default:    return 0;
    endcase
  endfunction

  // byte k of the line repeats byte (k mod size) of the pattern where the mask is set
  function automatic logic [`WR_LINE_W-1:0] expected_line(
    input logic [`WR_PAT_W-1:0] pat,
    input pat_size_e sz,
    input logic [`WR_LINE_BYTES-1:0] mask
  );
    int nbytes;
    logic [`WR_LINE_W-1:0] line;
    nbytes = size_in_bytes(sz);
    line = '0;
    for (int k = 0; k < `WR_LINE_BYTES; k++)
    begin
      if (mask[k] && (nbytes != 0))
        line[8*k +: 8] = pat[8*(k % nbytes) +: 8];
    end
    return line;
  endfunction

  task automatic flag_error(input string what);
    $display("ERROR %s: %s", test_name, what);
    errors++;
  endtask

  task automatic report_mismatch(
    input string field,
    input int n,
    input logic [`WR_LINE_W-1:0] exp_val,
    input logic [`WR_LINE_W-1:0] act_val
  );
    $display("MISMATCH %s %s of write %0d: expected %0h actual %0h",
             test_name, field, n, exp_val, act_val);
    errors++;
  endtask

  task automatic open_test(input string name, input int n_writes, input bit aborting);
    test_name  = name;
    exp_count  = n_writes;
    abort_row  = aborting;
    launched   = 1'b0;
    phase_open = 1'b0;
    abort_seen = 1'b0;
    abort_age  = 0;
    aw_count   = 0;
    w_count    = 0;
    done_count = 0;
    errors     = 0;
  endtask

  task automatic close_test();
    if (!launched)
      flag_error("the start pulse was never accepted");
    if (done_count != 1)
      flag_error($sformatf("done pulsed %0d times instead of once", done_count));
    if (abort_row && !abort_seen)
      flag_error("abort was not sampled while the phase was busy");
    tests_run++;
    total_errors += errors;
    if (errors == 0)
      $display("PASS %s: %0d writes accepted", test_name, aw_count);
    else
    begin
      tests_failed++;
      $display("FAIL %s: %0d errors", test_name, errors);
    end
  endtask

  always @(posedge clk)
  begin : monitor
    logic [`WR_ADDR_W-1:0] exp_addr;
    logic [`WR_PAT_W-1:0] exp_pat;
    logic [`WR_LINE_W-1:0] exp_line;
    if (reset_n)
    begin
      // busy and done change on the edge after the abort edge and are seen here one edge later
      if (abort_age == 1)
      begin
        if (!i_busy || i_done)
          flag_error("busy or done changed too early after abort");
        abort_age = 2;
      end
      else if (abort_age == 2)
      begin
        if (i_busy || !i_done)
          flag_error("busy did not fall with a done pulse one edge after abort");
        abort_age = 0;
      end
      if (i_start && !i_busy)
      begin
        cur_cfg    = i_cfg;
        launched   = 1'b1;
        phase_open = 1'b1;
      end
      if ((i_aw.valid || i_w.valid) && !phase_open)
        flag_error("a write valid is high outside a running phase");
      if (phase_open && i_aw.valid && i_aw_ready)
      begin
        if (!i_busy)
          flag_error("an address write was accepted while busy was low");
        if (aw_count >= exp_count)
          flag_error($sformatf("extra address write with id %0d", i_aw.id));
        else
        begin
          exp_addr = cur_cfg.x + `WR_ADDR_W'(cur_cfg.rai) * `WR_ADDR_W'(aw_count);
          if (i_aw.addr !== exp_addr)
            report_mismatch("aw.addr", aw_count, `WR_LINE_W'(exp_addr), `WR_LINE_W'(i_aw.addr));
          if (i_aw.id !== `WR_N_W'(aw_count))
            report_mismatch("aw.id", aw_count, `WR_LINE_W'(aw_count), `WR_LINE_W'(i_aw.id));
        end
        aw_count++;
      end
      if (phase_open && i_w.valid && i_w_ready)
      begin
        if (!i_busy)
          flag_error("a data write was accepted while busy was low");
        if (w_count >= exp_count)
          flag_error("extra data write beyond the expected sequence");
        else
        begin
          exp_pat  = cur_cfg.p + `WR_PAT_W'(w_count);
          exp_line = expected_line(exp_pat, cur_cfg.pat_size, cur_cfg.byte_mask);
          if (i_w.data !== exp_line)
            report_mismatch("w.data", w_count, exp_line, i_w.data);
          if (i_w.strb !== cur_cfg.byte_mask)
            report_mismatch("w.strb", w_count, `WR_LINE_W'(cur_cfg.byte_mask),
                            `WR_LINE_W'(i_w.strb));
          if (i_w.last !== 1'b1)
            report_mismatch("w.last", w_count, `WR_LINE_W'(1), `WR_LINE_W'(i_w.last));
        end
        w_count++;
      end
      if (i_done)
      begin
        done_count++;
        if (i_busy)
          flag_error("busy is still high while done pulses");
        if (!abort_row && ((aw_count != exp_count) || (w_count != exp_count)))
          flag_error($sformatf("done after %0d address and %0d data writes out of %0d",
                               aw_count, w_count, exp_count));
        phase_open = 1'b0;
      end
      // writes accepted on the abort edge itself still count as issued
      if (i_abort && i_busy && phase_open && !abort_seen)
      begin
        abort_seen = 1'b1;
        phase_open = 1'b0;
        abort_age  = 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/wr_addr_pattern_pipe.sv ====
// ==============================
// fixed latency of three cycles from stage 1 to the FIFO write
// i_cfg must stay stable for the whole phase
// ==============================
`default_nettype none
`timescale 1ns/100ps

`include "wr_defines.svh"

module wr_addr_pattern_pipe (
  input  logic clk,
  input  logic reset_n,
  input  logic i_launch,
  input  logic i_active,
  input  wr_cfg_pkg::wr_cfg_t i_cfg,
  input  logic i_thresh,
  output wr_stream_pkg::wr_entry_t o_entry,
  output logic o_entry_valid,
  output logic o_gen_done
);
  import wr_cfg_pkg::*;

  logic [`WR_N_W-1:0] last_n;
  logic [`WR_ADDR_W-1:0] rai_ext;

  logic s1_valid;
  logic [`WR_N_W-1:0] s1_n;
  logic [`WR_PAT_W-1:0] s1_p;
  logic [`WR_PAT_W-1:0] s1_trim;

  logic s2_valid;
  logic [`WR_N_W-1:0] s2_n;
  logic [`WR_ADDR_W-1:0] s2_off;
  logic [`WR_PAT_W-1:0] s2_pat;

  logic s3_valid;
  logic [`WR_N_W-1:0] s3_n;
  logic [`WR_ADDR_W-1:0] s3_addr;
  logic [`WR_PAT_W-1:0] s3_pat;

  // single transaction mode stops after N equal to 0
  assign last_n  = i_cfg.single ? '0 : i_cfg.nai;
  assign rai_ext = {{(`WR_ADDR_W - `WR_RAI_W){1'b0}}, i_cfg.rai};

  // keep only pat_size low bytes, unknown sizes give a zero pattern
  always_comb
  begin
    case (i_cfg.pat_size)
      PAT_SIZE_4: s1_trim = s1_p;
      PAT_SIZE_2: s1_trim = {16'h0000, s1_p[15:0]};
      PAT_SIZE_1: s1_trim = {24'h000000, s1_p[7:0]};
      default:    s1_trim = '0;
    endcase
  end

  // stage 1 holds the last emitted N, and a new item appears only below threshold
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      s1_valid <= 1'b0;
      s1_n     <= '0;
    end
    else if (i_launch)
    begin
      s1_valid <= 1'b1;
      s1_n     <= '0;
    end
    else if (!i_active || i_thresh)
      s1_valid <= 1'b0;
    else if (s1_n < last_n)
    begin
      s1_valid <= 1'b1;
      s1_n     <= s1_n + 1'b1;
    end
    else
      s1_valid <= 1'b0;
  end

  // the pattern steps together with N
  always_ff @(posedge clk)
  begin
    if (i_launch)
      s1_p <= i_cfg.p;
    else if (i_active && !i_thresh && (s1_n < last_n))
      s1_p <= s1_p + 1'b1;
  end

  // stages 2 and 3 always advance, so items in flight still reach the FIFO
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      s2_valid   <= 1'b0;
      s3_valid   <= 1'b0;
      o_gen_done <= 1'b0;
    end
    else
    begin
      s2_valid <= i_active && s1_valid;
      s3_valid <= i_active && s2_valid;
      // gen_done rises once the last item has been written to the FIFO
      if (i_launch)
        o_gen_done <= 1'b0;
      else if (s3_valid && (s3_n == last_n))
        o_gen_done <= 1'b1;
    end
  end

  // N times RAI is built by adding rai once per emitted item
  always_ff @(posedge clk)
  begin
    if (s1_valid)
    begin
      s2_n   <= s1_n;
      s2_off <= (s1_n == '0) ? '0 : s2_off + rai_ext;
      s2_pat <= s1_trim;
    end
    if (s2_valid)
    begin
      s3_n    <= s2_n;
      s3_addr <= i_cfg.x + s2_off;
      s3_pat  <= s2_pat;
    end
  end

  assign o_entry.n       = s3_n;
  assign o_entry.addr    = s3_addr;
  assign o_entry.pattern = s3_pat;
  assign o_entry_valid   = s3_valid;

endmodule

`default_nettype wire

// ==== src/wr_cfg_pkg.sv ====
// ==============================
// phase configuration types, held stable by the user while busy
// ==============================
`default_nettype none

`include "wr_defines.svh"

package wr_cfg_pkg;

  // pattern size in bytes, taken from the low end of the pattern
  // codes outside this list give an all-zero pattern
  typedef enum logic [2:0] {
    PAT_SIZE_0 = 3'd0,
    PAT_SIZE_1 = 3'd1,
    PAT_SIZE_2 = 3'd2,
    PAT_SIZE_4 = 3'd4
  } pat_size_e;

  // everything one start pulse needs, 199 bits
  typedef struct packed {
    // base address X of the first write
    logic [`WR_ADDR_W-1:0] x;
    // start pattern P, incremented once per write
    logic [`WR_PAT_W-1:0] p;
    // real address increment between consecutive writes
    logic [`WR_RAI_W-1:0] rai;
    // last N value, so NAI+1 writes are made
    logic [`WR_N_W-1:0] nai;
    pat_size_e pat_size;
    // one bit per byte of the line, also used as the write strobes
    logic [`WR_LINE_BYTES-1:0] byte_mask;
    // when set only the write for N equal to 0 is issued
    logic single;
  } wr_cfg_t;

endpackage

`default_nettype wire

// ==== src/wr_defines.svh ====
// ==============================
// widths and sizing for the write phase, shared by packages and RTL
// the FIFO threshold must leave room for the three pipeline stages
// ==============================
`ifndef WR_DEFINES_SVH
`define WR_DEFINES_SVH

// byte address of a cache line write
`define WR_ADDR_W 52
// pattern register width, trimmed later to the programmed size
`define WR_PAT_W 32
// width of N and of the increment count NAI
`define WR_N_W 9
// width of the real address increment
`define WR_RAI_W 38

// one write is always a full 64-byte line in a single beat
`define WR_LINE_BYTES 64
`define WR_LINE_W 512

// entry FIFO between the pipeline and the issue unit
`define WR_FIFO_DEPTH 16
`define WR_FIFO_PTR_W 4
// generation pauses at this fill level, leaving 6 spare places
`define WR_FIFO_THRESH 10

`endif

// ==== src/wr_entry_fifo.sv ====
// ==============================
// read-ahead FIFO, the head entry is valid while o_empty is low
// pushes while full and pops while empty are ignored
// ==============================
`default_nettype none
`timescale 1ns/100ps

`include "wr_defines.svh"

module wr_entry_fifo (
  input  logic clk,
  input  logic reset_n,
  input  logic i_clear,
  input  logic i_push,
  input  wr_stream_pkg::wr_entry_t i_entry,
  input  logic i_pop,
  output wr_stream_pkg::wr_entry_t o_entry,
  output logic o_empty,
  output logic o_full,
  output logic o_thresh
);
  import wr_stream_pkg::*;

  wr_entry_t mem [`WR_FIFO_DEPTH];
  logic [`WR_FIFO_PTR_W-1:0] wr_ptr;
  logic [`WR_FIFO_PTR_W-1:0] rd_ptr;
  // one bit wider than the pointers so that full can be told from empty
  logic [`WR_FIFO_PTR_W:0] count;
  logic push_ok;
  logic pop_ok;

  assign push_ok = i_push && !o_full && !i_clear;
  assign pop_ok  = i_pop && !o_empty && !i_clear;

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leave the count unchanged
      if (push_ok && !pop_ok)
        count <= count + 1'b1;
      else if (pop_ok && !push_ok)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_ok)
      mem[wr_ptr] <= i_entry;
  end

  assign o_entry  = mem[rd_ptr];
  assign o_empty  = (count == '0);
  assign o_full   = (count == `WR_FIFO_DEPTH);
  assign o_thresh = (count >= `WR_FIFO_THRESH);

endmodule

`default_nettype wire

// ==== src/wr_line_issue.sv ====
// ==============================
// one entry in flight, AW and W accepted independently
// byte mask and pattern size must stay stable while busy
// ==============================
`default_nettype none
`timescale 1ns/100ps

`include "wr_defines.svh"

module wr_line_issue (
  input  logic clk,
  input  logic reset_n,
  input  logic i_active,
  input  wr_stream_pkg::wr_entry_t i_entry,
  input  logic i_empty,
  input  logic [`WR_LINE_BYTES-1:0] i_byte_mask,
  input  wr_cfg_pkg::pat_size_e i_pat_size,
  input  logic i_aw_ready,
  input  logic i_w_ready,
  output logic o_pop,
  output wr_stream_pkg::wr_aw_t o_aw,
  output wr_stream_pkg::wr_w_t o_w,
  output logic o_idle
);
  import wr_cfg_pkg::*;
  import wr_stream_pkg::*;

  wr_entry_t ent;
  logic aw_pend;
  logic w_pend;
  logic aw_fire;
  logic w_fire;
  logic finish;
  logic [1:0] sel_mask;
  logic [`WR_LINE_W-1:0] line_data;

  // valids fall in the same cycle that the phase leaves RUN or DRAIN
  assign aw_fire = aw_pend && i_active && i_aw_ready;
  assign w_fire  = w_pend && i_active && i_w_ready;
  assign o_idle  = !aw_pend && !w_pend;
  // the held entry is done once each channel has been accepted
  assign finish  = !o_idle && (!aw_pend || aw_fire) && (!w_pend || w_fire);
  // popping on the finishing cycle lets the next entry follow directly
  assign o_pop   = i_active && !i_empty && (o_idle || finish);

  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_active)
    begin
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end
    else if (o_pop)
    begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end
    else
    begin
      if (aw_fire)
        aw_pend <= 1'b0;
      if (w_fire)
        w_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (o_pop)
      ent <= i_entry;
  end

  // byte k of the line takes byte (k mod size) of the pattern
  // size 1 always picks byte 0, and sizes 0 and unknown carry a zero pattern
  always_comb
  begin
    case (i_pat_size)
      PAT_SIZE_4: sel_mask = 2'b11;
      PAT_SIZE_2: sel_mask = 2'b01;
      default:    sel_mask = 2'b00;
    endcase
  end

  always_comb
  begin
    line_data = '0;
    for (int k = 0; k < `WR_LINE_BYTES; k++)
    begin
      if (i_byte_mask[k])
        line_data[8*k +: 8] = ent.pattern[8*(2'(k) & sel_mask) +: 8];
    end
  end

  always_comb
  begin
    o_aw.valid = aw_pend && i_active;
    o_aw.addr  = ent.addr;
    o_aw.id    = ent.n;
    o_w.valid  = w_pend && i_active;
    o_w.data   = line_data;
    o_w.strb   = i_byte_mask;
    // each write is a single beat
    o_w.last   = 1'b1;
  end

endmodule

`default_nettype wire

// ==== src/wr_phase_ctrl.sv ====
// ==============================
// start is only seen in IDLE, abort only while busy
// the phase ends when the last write is accepted on both channels
// ==============================
`default_nettype none
`timescale 1ns/100ps

module wr_phase_ctrl (
  input  logic clk,
  input  logic reset_n,
  input  logic i_start,
  input  logic i_abort,
  input  logic i_gen_done,
  input  logic i_fifo_empty,
  input  logic i_issue_idle,
  output logic o_launch,
  output logic o_finish,
  output logic o_busy,
  output logic o_done,
  output wr_stream_pkg::ctrl_state_e o_state
);
  import wr_stream_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;

  // start accepted, this pulse loads the pipeline and clears the FIFO
  assign o_launch = (state == IDLE) && i_start;
  // COMPLETE lasts exactly one cycle
  assign o_finish = (state == COMPLETE);
  assign o_state  = state;

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        if (i_start)
          next_state = RUN;
      end
      RUN:
      begin
        // abort wins over every other condition while busy
        if (i_abort)
          next_state = COMPLETE;
        else if (i_gen_done)
          next_state = DRAIN;
      end
      DRAIN:
      begin
        // the pipeline is finished, wait for FIFO and issue unit to empty
        if (i_abort)
          next_state = COMPLETE;
        else if (i_gen_done && i_fifo_empty && i_issue_idle)
          next_state = COMPLETE;
      end
      default:
        next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= IDLE;
    else
      state <= next_state;
  end

  // busy rises after the start edge and falls on the edge that leaves COMPLETE
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      o_busy <= 1'b0;
    else if (o_launch)
      o_busy <= 1'b1;
    else if (o_finish)
      o_busy <= 1'b0;
  end

  // done pulses on the same edge where busy falls
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      o_done <= 1'b0;
    else
      o_done <= o_finish;
  end

endmodule

`default_nettype wire

// ==== src/wr_phase_top.sv ====
// ==============================
// i_cfg must be held while o_busy is high
// o_done pulses once per phase, also after an abort
// ==============================
`default_nettype none
`timescale 1ns/100ps

module wr_phase_top (
  input  logic clk,
  input  logic reset_n,
  input  logic i_start,
  input  wr_cfg_pkg::wr_cfg_t i_cfg,
  input  logic i_abort,
  output wr_stream_pkg::wr_aw_t o_aw,
  input  logic i_aw_ready,
  output wr_stream_pkg::wr_w_t o_w,
  input  logic i_w_ready,
  output logic o_busy,
  output logic o_done
);
  import wr_stream_pkg::*;

  logic launch;
  logic finish;
  logic gen_done;
  logic fifo_empty;
  logic fifo_thresh;
  logic fifo_pop;
  logic pipe_valid;
  logic issue_idle;
  ctrl_state_e ctrl_state;
  wr_entry_t pipe_entry;
  wr_entry_t fifo_entry;

  // pipeline and issue unit only work while the phase runs or drains
  wire active = (ctrl_state == RUN) || (ctrl_state == DRAIN);
  // entries left behind by an abort are dropped at finish, and again at launch
  wire fifo_clear = launch || finish;

  wr_phase_ctrl ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_start      (i_start),
    .i_abort      (i_abort),
    .i_gen_done   (gen_done),
    .i_fifo_empty (fifo_empty),
    .i_issue_idle (issue_idle),
    .o_launch     (launch),
    .o_finish     (finish),
    .o_busy       (o_busy),
    .o_done       (o_done),
    .o_state      (ctrl_state)
  );

  wr_addr_pattern_pipe pipe_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_launch      (launch),
    .i_active      (active),
    .i_cfg         (i_cfg),
    .i_thresh      (fifo_thresh),
    .o_entry       (pipe_entry),
    .o_entry_valid (pipe_valid),
    .o_gen_done    (gen_done)
  );

  // the threshold keeps the FIFO from filling, so full is not needed here
  wr_entry_fifo fifo_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .i_clear  (fifo_clear),
    .i_push   (pipe_valid),
    .i_entry  (pipe_entry),
    .i_pop    (fifo_pop),
    .o_entry  (fifo_entry),
    .o_empty  (fifo_empty),
    .o_full   (),
    .o_thresh (fifo_thresh)
  );

  wr_line_issue issue_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_active    (active),
    .i_entry     (fifo_entry),
    .i_empty     (fifo_empty),
    .i_byte_mask (i_cfg.byte_mask),
    .i_pat_size  (i_cfg.pat_size),
    .i_aw_ready  (i_aw_ready),
    .i_w_ready   (i_w_ready),
    .o_pop       (fifo_pop),
    .o_aw        (o_aw),
    .o_w         (o_w),
    .o_idle      (issue_idle)
  );

endmodule

`default_nettype wire

// ==== src/wr_stream_pkg.sv ====
// ==============================
// types for FIFO entries, the two write channels and the phase FSM
// ==============================
`default_nettype none

`include "wr_defines.svh"

package wr_stream_pkg;

  // one generated write, 93 bits, carried through the entry FIFO
  typedef struct packed {
    logic [`WR_N_W-1:0] n;
    logic [`WR_ADDR_W-1:0] addr;
    // pattern already trimmed to the programmed size
    logic [`WR_PAT_W-1:0] pattern;
  } wr_entry_t;

  // write address channel, id carries the N value, 62 bits
  typedef struct packed {
    logic valid;
    logic [`WR_ADDR_W-1:0] addr;
    logic [`WR_N_W-1:0] id;
  } wr_aw_t;

  // write data channel, one beat per line so last is always set, 578 bits
  typedef struct packed {
    logic valid;
    logic [`WR_LINE_W-1:0] data;
    logic [`WR_LINE_BYTES-1:0] strb;
    logic last;
  } wr_w_t;

  // phase FSM, generation runs in RUN and the FIFO empties in DRAIN
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    RUN      = 2'd1,
    DRAIN    = 2'd2,
    COMPLETE = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire
